// ==== verilog/mips_wb_pkg.sv ====
// data width, register number width and load kind encoding for write-back

package mips_wb_pkg;

    //////////////////////////////
    // widths
    //////////////////////////////

    // one data word
    parameter int DATA_W = 32;

    // general-purpose register number
    parameter int GPR_W = 5;

    //////////////////////////////
    // load modes
    //////////////////////////////

    // load mode of the instruction in write-back
    // LK_NONE selects the non-load result
    typedef enum logic [2:0] {
        LK_NONE = 3'd0,
        // byte, signed and unsigned
        LK_LB   = 3'd1,
        LK_LBU  = 3'd2,
        // halfword, signed and unsigned
        LK_LH   = 3'd3,
        LK_LHU  = 3'd4,
        // full word
        LK_LW   = 3'd5,
        // unaligned partial word loads
        LK_LWL  = 3'd6,
        LK_LWR  = 3'd7
    } load_kind_t;

endpackage

// ==== verilog/wb_ctrl.sv ====
// write-back interlock: stage occupied flag, load, clear, RAM read and commit

`timescale 1ns/1ps

module wb_ctrl (
    input  logic clk,
    input  logic rst,
    input  logic mem_valid_i,
    input  logic commit_allowin_i,
    output logic wb_allowin_o,
    output logic stage_load_o,
    output logic stage_clear_o,
    output logic ram_re_o,
    output logic commit_o
);

    logic has_data;

    // stage can take a new instruction if empty or draining this cycle
    assign wb_allowin_o = !has_data || commit_allowin_i;

    // held instruction leaves the stage
    assign commit_o = has_data && commit_allowin_i;

    // accept from memory stage, start the RAM read in the same edge
    assign stage_load_o = mem_valid_i && wb_allowin_o;
    assign ram_re_o     = stage_load_o;

    // stage empties with nothing behind it
    assign stage_clear_o = commit_o && !mem_valid_i;

    always_ff @(posedge clk) begin
        if (!rst) begin
            has_data <= 1'b0;
        end else if (wb_allowin_o) begin
            has_data <= mem_valid_i;
        end
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    // memory stage must respect the interlock
    a_offer_only_when_allowed: assert property (
        @(posedge clk) disable iff (!rst)
        mem_valid_i |-> wb_allowin_o
    );

endmodule

// ==== verilog/wb_stage_reg.sv ====
// intersegment register between memory and write-back stages

`timescale 1ns/1ps

module wb_stage_reg import mips_wb_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              load_i,
    input  logic              clear_i,
    input  load_kind_t        kind_i,
    input  logic [GPR_W-1:0]  wnum_i,
    input  logic [DATA_W-1:0] addr_i,
    input  logic [DATA_W-1:0] rt_data_i,
    input  logic [DATA_W-1:0] result_i,
    input  logic              exc_risk_i,
    output load_kind_t        kind_o,
    output logic [GPR_W-1:0]  wnum_o,
    output logic [DATA_W-1:0] addr_o,
    output logic [DATA_W-1:0] rt_data_o,
    output logic [DATA_W-1:0] result_o,
    output logic              exc_risk_o
);

    // cleared stage looks like a non-load with no write
    always_ff @(posedge clk) begin
        if (!rst || clear_i) begin
            kind_o     <= LK_NONE;
            wnum_o     <= '0;
            addr_o     <= '0;
            rt_data_o  <= '0;
            result_o   <= '0;
            exc_risk_o <= 1'b0;
        end else if (load_i) begin
            kind_o     <= kind_i;
            wnum_o     <= wnum_i;
            addr_o     <= addr_i;
            rt_data_o  <= rt_data_i;
            result_o   <= result_i;
            exc_risk_o <= exc_risk_i;
        end
    end

    // held load mode stays a known encoding out of reset
    a_kind_legal: assert property (
        @(posedge clk) disable iff (!rst)
        !$isunknown(kind_o)
    );

endmodule

// ==== verilog/data_ram.sv ====
// word-addressed data RAM, registered read port and fill write port

`timescale 1ns/1ps

module data_ram import mips_wb_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic              clk,
    input  logic              re_i,
    input  logic [DATA_W-1:0] raddr_i,
    input  logic              we_i,
    input  logic [DATA_W-1:0] waddr_i,
    input  logic [DATA_W-1:0] wdata_i,
    output logic [DATA_W-1:0] rdata_o
);

    localparam int AW = $clog2(RAM_WORDS);

    logic [DATA_W-1:0] mem [RAM_WORDS];

    // byte address, drop the two offset bits
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem[waddr_i[AW+1:2]] <= wdata_i;
        end
    end

    // output register holds the last word until the next read
    always_ff @(posedge clk) begin
        if (re_i) begin
            rdata_o <= mem[raddr_i[AW+1:2]];
        end
    end

endmodule

// ==== verilog/load_align.sv ====
// load data extraction, sign/zero extension, LWL/LWR merge and result select

`timescale 1ns/1ps

module load_align import mips_wb_pkg::*; (
    input  load_kind_t        kind_i,
    input  logic [1:0]        addr_lo_i,
    input  logic [DATA_W-1:0] mem_word_i,
    input  logic [DATA_W-1:0] rt_data_i,
    input  logic [DATA_W-1:0] result_i,
    output logic [DATA_W-1:0] wdata_o
);

    logic [7:0]        byte_sel;
    logic [15:0]       half_sel;
    logic [DATA_W-1:0] lwl_data;
    logic [DATA_W-1:0] lwr_data;

    //////////////////////////////
    // lane selection
    //////////////////////////////

    // little-endian, byte 0 in the low lane
    always_comb begin
        case (addr_lo_i)
            2'd0:    byte_sel = mem_word_i[7:0];
            2'd1:    byte_sel = mem_word_i[15:8];
            2'd2:    byte_sel = mem_word_i[23:16];
            default: byte_sel = mem_word_i[31:24];
        endcase
    end

    assign half_sel = addr_lo_i[1] ? mem_word_i[31:16] : mem_word_i[15:0];

    // left part: word moved up, low bytes kept from rt
    always_comb begin
        case (addr_lo_i)
            2'd0:    lwl_data = {mem_word_i[7:0], rt_data_i[23:0]};
            2'd1:    lwl_data = {mem_word_i[15:0], rt_data_i[15:0]};
            2'd2:    lwl_data = {mem_word_i[23:0], rt_data_i[7:0]};
            default: lwl_data = mem_word_i;
        endcase
    end

    // right part: word moved down, high bytes kept from rt
    always_comb begin
        case (addr_lo_i)
            2'd0:    lwr_data = mem_word_i;
            2'd1:    lwr_data = {rt_data_i[31:24], mem_word_i[31:8]};
            2'd2:    lwr_data = {rt_data_i[31:16], mem_word_i[31:16]};
            default: lwr_data = {rt_data_i[31:8], mem_word_i[31:24]};
        endcase
    end

    //////////////////////////////
    // result select
    //////////////////////////////

    always_comb begin
        case (kind_i)
            LK_LB:   wdata_o = {{24{byte_sel[7]}}, byte_sel};
            LK_LBU:  wdata_o = {24'd0, byte_sel};
            LK_LH:   wdata_o = {{16{half_sel[15]}}, half_sel};
            LK_LHU:  wdata_o = {16'd0, half_sel};
            LK_LW:   wdata_o = mem_word_i;
            LK_LWL:  wdata_o = lwl_data;
            LK_LWR:  wdata_o = lwr_data;
            default: wdata_o = result_i;
        endcase
    end

    // misaligned halfwords are trapped upstream and never reach here
    always_comb begin
        if (kind_i == LK_LH || kind_i == LK_LHU) begin
            a_half_aligned: assert final (addr_lo_i[0] == 1'b0);
        end
    end

endmodule

// ==== verilog/gpr_file.sv ====
// general-purpose register file, 32 entries, one write and one read port

`timescale 1ns/1ps

module gpr_file import mips_wb_pkg::*; (
    input  logic              clk,
    input  logic              rst,
    input  logic              we_i,
    input  logic [GPR_W-1:0]  waddr_i,
    input  logic [DATA_W-1:0] wdata_i,
    input  logic [GPR_W-1:0]  raddr_i,
    output logic [DATA_W-1:0] rdata_o
);

    localparam int NREGS = 1 << GPR_W;

    logic [DATA_W-1:0] regs [NREGS];

    // $zero never takes a write
    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we_i && waddr_i != '0) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // combinational read, register 0 forced to zero
    assign rdata_o = (raddr_i == '0) ? '0 : regs[raddr_i];

endmodule

// ==== verilog/wb_top.sv ====
// memory-return and write-back top level with forwarding outputs and trace register

`timescale 1ns/1ps

module wb_top import mips_wb_pkg::*; #(
    parameter int RAM_WORDS = 256
) (
    input  logic              clk,
    input  logic              rst,
    // memory stage
    input  logic              mem_valid_i,
    input  load_kind_t        mem_kind_i,
    input  logic [GPR_W-1:0]  mem_wnum_i,
    input  logic [DATA_W-1:0] mem_addr_i,
    input  logic [DATA_W-1:0] mem_rt_data_i,
    input  logic [DATA_W-1:0] mem_result_i,
    input  logic              mem_exc_risk_i,
    output logic              wb_allowin_o,
    // commit side
    input  logic              commit_allowin_i,
    input  logic              commit_risk_i,
    output logic              wb_we_o,
    output logic [GPR_W-1:0]  wb_wnum_o,
    output logic [DATA_W-1:0] wb_wdata_o,
    output logic              wb_risk_o,
    // trace
    output logic              trace_we_o,
    output logic [DATA_W-1:0] trace_pc_o,
    output logic [GPR_W-1:0]  trace_wnum_o,
    output logic [DATA_W-1:0] trace_wdata_o,
    // RAM fill and register read-back
    input  logic              fill_we_i,
    input  logic [DATA_W-1:0] fill_addr_i,
    input  logic [DATA_W-1:0] fill_data_i,
    input  logic [GPR_W-1:0]  rf_raddr_i,
    output logic [DATA_W-1:0] rf_rdata_o
);

    logic              stage_load;
    logic              stage_clear;
    logic              ram_re;
    logic              commit;
    load_kind_t        st_kind;
    logic [GPR_W-1:0]  st_wnum;
    logic [DATA_W-1:0] st_addr;
    logic [DATA_W-1:0] st_rt_data;
    logic [DATA_W-1:0] st_result;
    logic              st_exc_risk;
    logic [DATA_W-1:0] ram_rdata;

    wb_ctrl u_ctrl (
        .clk              (clk),
        .rst              (rst),
        .mem_valid_i      (mem_valid_i),
        .commit_allowin_i (commit_allowin_i),
        .wb_allowin_o     (wb_allowin_o),
        .stage_load_o     (stage_load),
        .stage_clear_o    (stage_clear),
        .ram_re_o         (ram_re),
        .commit_o         (commit)
    );

    wb_stage_reg u_stage (
        .clk        (clk),
        .rst        (rst),
        .load_i     (stage_load),
        .clear_i    (stage_clear),
        .kind_i     (mem_kind_i),
        .wnum_i     (mem_wnum_i),
        .addr_i     (mem_addr_i),
        .rt_data_i  (mem_rt_data_i),
        .result_i   (mem_result_i),
        .exc_risk_i (mem_exc_risk_i),
        .kind_o     (st_kind),
        .wnum_o     (st_wnum),
        .addr_o     (st_addr),
        .rt_data_o  (st_rt_data),
        .result_o   (st_result),
        .exc_risk_o (st_exc_risk)
    );

    // read address comes straight from the memory stage on acceptance
    data_ram #(.RAM_WORDS(RAM_WORDS)) u_ram (
        .clk     (clk),
        .re_i    (ram_re),
        .raddr_i (mem_addr_i),
        .we_i    (fill_we_i),
        .waddr_i (fill_addr_i),
        .wdata_i (fill_data_i),
        .rdata_o (ram_rdata)
    );

    load_align u_align (
        .kind_i     (st_kind),
        .addr_lo_i  (st_addr[1:0]),
        .mem_word_i (ram_rdata),
        .rt_data_i  (st_rt_data),
        .result_i   (st_result),
        .wdata_o    (wb_wdata_o)
    );

    // register 0 means no write back
    assign wb_we_o   = commit && (st_wnum != '0);
    assign wb_wnum_o = st_wnum;
    assign wb_risk_o = st_exc_risk || commit_risk_i;

    gpr_file u_gpr (
        .clk     (clk),
        .rst     (rst),
        .we_i    (wb_we_o),
        .waddr_i (st_wnum),
        .wdata_i (wb_wdata_o),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

    //////////////////////////////
    // trace record
    //////////////////////////////

    // one cycle behind the commit it reports
    always_ff @(posedge clk) begin
        if (!rst) begin
            trace_we_o    <= 1'b0;
            trace_pc_o    <= '0;
            trace_wnum_o  <= '0;
            trace_wdata_o <= '0;
        end else begin
            trace_we_o    <= wb_we_o;
            trace_pc_o    <= st_addr;
            trace_wnum_o  <= st_wnum;
            trace_wdata_o <= wb_wdata_o;
        end
    end

endmodule

// ==== verif/wb_tb.sv ====
// testbench for the write-back subsystem: stim file driver, commit and trace checker, watchdog

`timescale 1ns/1ps

module wb_tb import mips_wb_pkg::*; ();

    // one expected register write and the trace record that follows it
    typedef struct packed {
        logic [DATA_W-1:0] addr;
        logic [GPR_W-1:0]  wnum;
        logic [DATA_W-1:0] data;
        logic              risk;
    } commit_t;

    logic              clk;
    logic              rst;
    logic              mem_valid_i;
    load_kind_t        mem_kind_i;
    logic [GPR_W-1:0]  mem_wnum_i;
    logic [DATA_W-1:0] mem_addr_i;
    logic [DATA_W-1:0] mem_rt_data_i;
    logic [DATA_W-1:0] mem_result_i;
    logic              mem_exc_risk_i;
    logic              wb_allowin_o;
    logic              commit_allowin_i;
    logic              commit_risk_i;
    logic              wb_we_o;
    logic [GPR_W-1:0]  wb_wnum_o;
    logic [DATA_W-1:0] wb_wdata_o;
    logic              wb_risk_o;
    logic              trace_we_o;
    logic [DATA_W-1:0] trace_pc_o;
    logic [GPR_W-1:0]  trace_wnum_o;
    logic [DATA_W-1:0] trace_wdata_o;
    logic              fill_we_i;
    logic [DATA_W-1:0] fill_addr_i;
    logic [DATA_W-1:0] fill_data_i;
    logic [GPR_W-1:0]  rf_raddr_i;
    logic [DATA_W-1:0] rf_rdata_o;

    string   recs[$];
    commit_t exp_q[$];
    commit_t last_commit;
    logic    trace_due = 1'b0;
    logic    loaded = 1'b0;
    int      errors = 0;

    wb_top #(.RAM_WORDS(256)) dut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////
    // helpers
    //////////////////////////////

    task automatic compare_word(input string name, input logic [DATA_W-1:0] got,
                                input logic [DATA_W-1:0] exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    // keep every record line, drop comments and blank lines
    task automatic read_stim();
        int    fd;
        string line;
        fd = $fopen("verif/wb_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file verif/wb_stim.txt");
            errors++;
            return;
        end
        while (!$feof(fd)) begin
            line = "";
            if ($fgets(line, fd) > 0 && line.len() > 1 && line[0] != "#") begin
                recs.push_back(line);
            end
        end
        $fclose(fd);
    endtask

    // bubble cycle with a random commit-side stall
    task automatic drive_idle();
        @(posedge clk);
        mem_valid_i      <= 1'b0;
        fill_we_i        <= 1'b0;
        commit_allowin_i <= 1'($urandom_range(1, 0));
        commit_risk_i    <= 1'($urandom_range(1, 0));
    endtask

    task automatic run_record(input string line);
        logic [7:0]        tag;
        logic [DATA_W-1:0] fld [8];
        commit_t           entry;
        void'($sscanf(line, "%c %h %h %h %h %h %h %h %h", tag,
                      fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6], fld[7]));
        case (tag)
            "F": begin
                @(posedge clk);
                mem_valid_i <= 1'b0;
                fill_we_i   <= 1'b1;
                fill_addr_i <= fld[0];
                fill_data_i <= fld[1];
            end
            "I": begin
                while ($urandom_range(3, 0) == 0) begin
                    drive_idle();
                end
                @(posedge clk);
                fill_we_i        <= 1'b0;
                mem_valid_i      <= 1'b1;
                // commit side open whenever something is offered
                commit_allowin_i <= 1'b1;
                commit_risk_i    <= 1'($urandom_range(1, 0));
                mem_kind_i       <= load_kind_t'(fld[0][2:0]);
                mem_wnum_i       <= fld[1][GPR_W-1:0];
                mem_addr_i       <= fld[2];
                mem_rt_data_i    <= fld[3];
                mem_result_i     <= fld[4];
                mem_exc_risk_i   <= fld[5][0];
                if (fld[1][GPR_W-1:0] != '0) begin
                    entry.addr = fld[2];
                    entry.wnum = fld[1][GPR_W-1:0];
                    entry.data = fld[6];
                    entry.risk = fld[7][0];
                    exp_q.push_back(entry);
                end
            end
            "R": begin
                // all earlier writes must have reached the register file
                drive_idle();
                while (exp_q.size() != 0) begin
                    drive_idle();
                end
                rf_raddr_i <= fld[0][GPR_W-1:0];
                @(negedge clk);
                compare_word("rf_rdata_o", rf_rdata_o, fld[1]);
            end
            default: begin
                $display("unknown stimulus record: %s", line);
                errors++;
            end
        endcase
    endtask

    //////////////////////////////
    // commit and trace checker
    //////////////////////////////

    always @(negedge clk) begin
        if (rst) begin
            if (mem_valid_i && !wb_allowin_o) begin
                $display("%0t: instruction offered while the stage refused it", $time);
                errors++;
            end
            if (trace_due) begin
                if (!trace_we_o) begin
                    $display("%0t: no trace record after commit of r%0d", $time,
                             last_commit.wnum);
                    errors++;
                end
                compare_word("trace_pc_o", trace_pc_o, last_commit.addr);
                compare_word("trace_wnum_o", DATA_W'(trace_wnum_o), DATA_W'(last_commit.wnum));
                compare_word("trace_wdata_o", trace_wdata_o, last_commit.data);
            end else if (trace_we_o) begin
                $display("%0t: trace record without a commit in the cycle before", $time);
                errors++;
            end
            trace_due = 1'b0;
            if (wb_we_o) begin
                if (exp_q.size() == 0) begin
                    $display("%0t: commit of r%0d with no instruction pending", $time,
                             wb_wnum_o);
                    errors++;
                end else begin
                    last_commit = exp_q.pop_front();
                    trace_due = 1'b1;
                    compare_word("wb_wnum_o", DATA_W'(wb_wnum_o), DATA_W'(last_commit.wnum));
                    compare_word("wb_wdata_o", wb_wdata_o, last_commit.data);
                    compare_word("wb_risk_o", DATA_W'(wb_risk_o),
                                 DATA_W'(last_commit.risk | commit_risk_i));
                end
            end
        end
    end

    //////////////////////////////
    // main sequence and watchdog
    //////////////////////////////

    initial begin
        int drain;
        void'($urandom(14763));
        rst              <= 1'b0;
        mem_valid_i      <= 1'b0;
        mem_kind_i       <= LK_NONE;
        mem_wnum_i       <= '0;
        mem_addr_i       <= '0;
        mem_rt_data_i    <= '0;
        mem_result_i     <= '0;
        mem_exc_risk_i   <= 1'b0;
        commit_allowin_i <= 1'b1;
        commit_risk_i    <= 1'b0;
        fill_we_i        <= 1'b0;
        fill_addr_i      <= '0;
        fill_data_i      <= '0;
        rf_raddr_i       <= '0;
        read_stim();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        rst <= 1'b1;
        foreach (recs[i]) begin
            run_record(recs[i]);
        end
        // let the last commits and their trace records go through
        drain = 0;
        while (exp_q.size() != 0 && drain < 50) begin
            drive_idle();
            drain++;
        end
        repeat (3) drive_idle();
        if (exp_q.size() != 0) begin
            $display("%0d accepted instructions never committed", exp_q.size());
            errors++;
        end
        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

    initial begin
        wait (loaded);
        repeat ((recs.size() + 10) * 40) @(posedge clk);
        $display("watchdog expired, run did not finish in %0d cycles", (recs.size() + 10) * 40);
        $display("sim failed");
        $finish;
    end

endmodule

// ==== verif/wb_stim.txt ====
# F addr word   |   R reg expected
# I kind wnum addr rt_data result risk exp_wdata exp_risk   (all hex)
F 00000000 8765F4A1
F 00000004 11223344
F 00000008 7F80017E
I 1 01 00000000 00000000 00000000 0 FFFFFFA1 0
I 1 02 00000001 00000000 00000000 1 FFFFFFF4 1
I 1 03 00000002 00000000 00000000 0 00000065 0
I 1 04 00000003 00000000 00000000 0 FFFFFF87 0
I 2 05 00000000 00000000 00000000 0 000000A1 0
I 2 06 00000001 00000000 00000000 0 000000F4 0
I 2 07 00000002 00000000 00000000 0 00000065 0
I 2 08 00000003 00000000 00000000 1 00000087 1
I 3 09 00000000 00000000 00000000 0 FFFFF4A1 0
I 3 0A 00000002 00000000 00000000 0 FFFF8765 0
I 3 0B 00000008 00000000 00000000 0 0000017E 0
I 4 0C 00000000 00000000 00000000 0 0000F4A1 0
I 4 0D 00000002 00000000 00000000 1 00008765 1
I 4 0E 0000000A 00000000 00000000 0 00007F80 0
I 5 0F 00000004 00000000 00000000 0 11223344 0
I 6 10 00000004 AABBCCDD 00000000 0 44BBCCDD 0
I 6 11 00000005 AABBCCDD 00000000 0 3344CCDD 0
I 6 12 00000006 AABBCCDD 00000000 0 223344DD 0
I 6 13 00000007 AABBCCDD 00000000 0 11223344 0
I 7 14 00000004 AABBCCDD 00000000 0 11223344 0
I 7 15 00000005 AABBCCDD 00000000 0 AA112233 0
I 7 16 00000006 AABBCCDD 00000000 1 AABB1122 1
I 7 17 00000007 AABBCCDD 00000000 0 AABBCC11 0
I 0 18 00000000 00000000 12345678 1 12345678 1
I 5 00 00000004 00000000 00000000 0 11223344 0
I 0 01 00000000 00000000 DEADBEEF 0 DEADBEEF 0
R 00 00000000
R 01 DEADBEEF
R 18 12345678
R 17 AABBCC11
R 0A FFFF8765
R 1F 00000000

// ==== sim.f ====
verilog/mips_wb_pkg.sv
verilog/wb_ctrl.sv
verilog/wb_stage_reg.sv
verilog/data_ram.sv
verilog/load_align.sv
verilog/gpr_file.sv
verilog/wb_top.sv
verif/wb_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = wb_tb
FILELIST  = sim.f
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
PASS_MSG  = sim passed

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	@out="$$(./$(SIM_BIN))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
